/* clint/clint_axi_rd.sv */
`timescale 1ns/1ps
`include "clint_params.svh"

module clint_axi_rd (
    input  logic                         aclk,
    input  logic                         areset_n,

    input  logic                         ar_valid_i,
    output logic                         ar_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ar_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]     ar_id_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    ar_len_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   ar_size_i,
    input  logic [`AXI_BURST_WIDTH-1:0]  ar_burst_i,

    output logic                         r_valid_o,
    input  logic                         r_ready_i,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data_o,
    output clint_pkg::clint_resp_e       r_resp_o,
    output logic                         r_last_o,
    output logic [`AXI_ID_WIDTH-1:0]     r_id_o,

    output logic [`AXI_ADDR_WIDTH-1:0]   rd_addr_o,
    input  logic [`AXI_DATA_WIDTH-1:0]   rd_data_i,
    input  logic                         rd_hit_i
);
    import clint_pkg::*;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

    rd_state_e                  state;
    logic [`AXI_ADDR_WIDTH-1:0] addr_q;
    logic                       ar_fire;
    logic                       r_fire;

    assign ar_ready_o = (state == RD_IDLE);
    assign r_valid_o  = (state == RD_DATA);
    assign r_last_o   = r_valid_o;
    assign ar_fire    = ar_valid_i & ar_ready_o;
    assign r_fire     = r_valid_o & r_ready_i;

    // the register file sees the incoming address while idle so the beat
    // can be captured on the same edge as the address transfer.
    assign rd_addr_o = (state == RD_IDLE) ? ar_addr_i : addr_q;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_fire) begin
                        state <= RD_IDLE;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    // snapshot of the register, so a stalled beat does not follow mtime.
    always_ff @(posedge aclk) begin
        if (ar_fire) begin
            addr_q   <= ar_addr_i;
            r_id_o   <= ar_id_i;
            r_data_o <= rd_data_i;
            r_resp_o <= rd_hit_i ? OKAY : SLVERR;
        end
    end

    ar_single_beat: assert property (@(posedge aclk) disable iff (areset_n)
        ar_fire |-> (ar_len_i == '0) && (ar_size_i == `AXI_SIZE_WIDTH'(2))
                    && (ar_burst_i == `AXI_BURST_WIDTH'(1)))
        else $error("read burst is not a single 32-bit INCR beat");

    r_hold_until_ready: assert property (@(posedge aclk) disable iff (areset_n)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
        else $error("read beat dropped or changed before r_ready");

endmodule

/* clint/clint_axi_wr.sv */
`timescale 1ns/1ps
`include "clint_params.svh"

module clint_axi_wr (
    input  logic                         aclk,
    input  logic                         areset_n,

    input  logic                         aw_valid_i,
    output logic                         aw_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0]   aw_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]     aw_id_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    aw_len_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   aw_size_i,
    input  logic [`AXI_BURST_WIDTH-1:0]  aw_burst_i,

    input  logic                         w_valid_i,
    output logic                         w_ready_o,
    input  logic [`AXI_DATA_WIDTH-1:0]   w_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0]   w_strb_i,
    input  logic                         w_last_i,

    output logic                         b_valid_o,
    input  logic                         b_ready_i,
    output clint_pkg::clint_resp_e       b_resp_o,
    output logic [`AXI_ID_WIDTH-1:0]     b_id_o,

    output logic                         wr_en_o,
    output logic [`AXI_ADDR_WIDTH-1:0]   wr_addr_o,
    output logic [`AXI_DATA_WIDTH-1:0]   wr_data_o,
    output logic [`AXI_STRB_WIDTH-1:0]   wr_strb_o,
    input  logic                         wr_hit_i
);
    import clint_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e                  state;
    logic [`AXI_ADDR_WIDTH-1:0] addr_q;
    logic                       aw_fire;
    logic                       w_fire;
    logic                       b_fire;

    assign aw_ready_o = (state == WR_IDLE);
    assign w_ready_o  = (state == WR_DATA);
    assign b_valid_o  = (state == WR_RESP);
    assign aw_fire    = aw_valid_i & aw_ready_o;
    assign w_fire     = w_valid_i & w_ready_o;
    assign b_fire     = b_valid_o & b_ready_i;

    // the accepted data beat goes straight to the register file as a pulse.
    assign wr_en_o   = w_fire;
    assign wr_addr_o = addr_q;
    assign wr_data_o = w_data_i;
    assign wr_strb_o = w_strb_i;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_fire) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_fire) begin
            addr_q <= aw_addr_i;
            b_id_o <= aw_id_i;
        end
        // the hit flag is valid in the same cycle as the write pulse.
        if (w_fire) begin
            b_resp_o <= wr_hit_i ? OKAY : SLVERR;
        end
    end

    aw_single_beat: assert property (@(posedge aclk) disable iff (areset_n)
        aw_fire |-> (aw_len_i == '0) && (aw_size_i == `AXI_SIZE_WIDTH'(2))
                    && (aw_burst_i == `AXI_BURST_WIDTH'(1)))
        else $error("write burst is not a single 32-bit INCR beat");

    w_last_on_beat: assert property (@(posedge aclk) disable iff (areset_n)
        w_fire |-> w_last_i)
        else $error("single write beat arrived without w_last");

endmodule

/* clint/clint_regs.sv */
`timescale 1ns/1ps
`include "clint_params.svh"

module clint_regs (
    input  logic                         aclk,
    input  logic                         areset_n,

    input  logic [`AXI_ADDR_WIDTH-1:0]   rd_addr_i,
    output logic [`AXI_DATA_WIDTH-1:0]   rd_data_o,
    output logic                         rd_hit_o,

    input  logic                         wr_en_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]   wr_addr_i,
    input  logic [`AXI_DATA_WIDTH-1:0]   wr_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0]   wr_strb_i,
    output logic                         wr_hit_o,

    output logic                         mtip_o,
    output logic                         msip_o
);
    import clint_pkg::*;

    localparam int TICK_W = (`CLINT_TICK_DIV > 1) ? $clog2(`CLINT_TICK_DIV) : 1;

    clint_word_u       mtime;
    clint_word_u       mtimecmp;
    logic              msip_q;
    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic              sel_msip;
    logic              sel_cmp_lo;
    logic              sel_cmp_hi;
    logic              sel_time_lo;
    logic              sel_time_hi;

    function automatic logic [`AXI_DATA_WIDTH-1:0] merge_bytes(
        input logic [`AXI_DATA_WIDTH-1:0] old_w,
        input logic [`AXI_DATA_WIDTH-1:0] new_w,
        input logic [`AXI_STRB_WIDTH-1:0] strb
    );
        logic [`AXI_DATA_WIDTH-1:0] res;
        res = old_w;
        for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    always_comb begin
        rd_hit_o = 1'b1;
        case (rd_addr_i)
            `CLINT_MSIP_ADDR:        rd_data_o = {31'd0, msip_q};
            `CLINT_MTIMECMP_LO_ADDR: rd_data_o = mtimecmp.half.lo;
            `CLINT_MTIMECMP_HI_ADDR: rd_data_o = mtimecmp.half.hi;
            `CLINT_MTIME_LO_ADDR:    rd_data_o = mtime.half.lo;
            `CLINT_MTIME_HI_ADDR:    rd_data_o = mtime.half.hi;
            default: begin
                rd_data_o = '0;
                rd_hit_o  = 1'b0;
            end
        endcase
    end

    assign sel_msip    = (wr_addr_i == `CLINT_MSIP_ADDR);
    assign sel_cmp_lo  = (wr_addr_i == `CLINT_MTIMECMP_LO_ADDR);
    assign sel_cmp_hi  = (wr_addr_i == `CLINT_MTIMECMP_HI_ADDR);
    assign sel_time_lo = (wr_addr_i == `CLINT_MTIME_LO_ADDR);
    assign sel_time_hi = (wr_addr_i == `CLINT_MTIME_HI_ADDR);
    assign wr_hit_o    = sel_msip | sel_cmp_lo | sel_cmp_hi | sel_time_lo | sel_time_hi;

    assign tick = (tick_cnt == TICK_W'(`CLINT_TICK_DIV - 1));

    always_ff @(posedge aclk) begin
        if (areset_n || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // a bus write to either half wins over the tick on the same edge.
    always_ff @(posedge aclk) begin
        if (areset_n) begin
            mtime.full <= '0;
        end else if (wr_en_i && sel_time_lo) begin
            mtime.half.lo <= merge_bytes(mtime.half.lo, wr_data_i, wr_strb_i);
        end else if (wr_en_i && sel_time_hi) begin
            mtime.half.hi <= merge_bytes(mtime.half.hi, wr_data_i, wr_strb_i);
        end else if (tick) begin
            mtime.full <= mtime.full + 64'd1;
        end
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            mtimecmp.full <= '1;
            msip_q        <= 1'b0;
        end else if (wr_en_i) begin
            if (sel_cmp_lo) begin
                mtimecmp.half.lo <= merge_bytes(mtimecmp.half.lo, wr_data_i, wr_strb_i);
            end
            if (sel_cmp_hi) begin
                mtimecmp.half.hi <= merge_bytes(mtimecmp.half.hi, wr_data_i, wr_strb_i);
            end
            if (sel_msip && wr_strb_i[0]) begin
                msip_q <= wr_data_i[0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            mtip_o <= 1'b0;
        end else begin
            mtip_o <= (mtime.full >= mtimecmp.full);
        end
    end

    assign msip_o = msip_q;

    // mtimecmp at its reset value of all ones keeps the timer interrupt low.
    mtip_quiet_at_max_cmp: assert property (@(posedge aclk) disable iff (areset_n)
        $rose(mtip_o) |-> !(&$past(mtimecmp.full)))
        else $error("timer interrupt raised with mtimecmp at all ones");

endmodule

/* clint/clint_top.sv */
`timescale 1ns/1ps
`include "clint_params.svh"

module clint_top (
    input  logic                         aclk,
    input  logic                         areset_n,

    input  logic                         aw_valid_i,
    output logic                         aw_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0]   aw_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]     aw_id_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    aw_len_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   aw_size_i,
    input  logic [`AXI_BURST_WIDTH-1:0]  aw_burst_i,

    input  logic                         w_valid_i,
    output logic                         w_ready_o,
    input  logic [`AXI_DATA_WIDTH-1:0]   w_data_i,
    input  logic [`AXI_STRB_WIDTH-1:0]   w_strb_i,
    input  logic                         w_last_i,

    output logic                         b_valid_o,
    input  logic                         b_ready_i,
    output logic [`AXI_RESP_WIDTH-1:0]   b_resp_o,
    output logic [`AXI_ID_WIDTH-1:0]     b_id_o,

    input  logic                         ar_valid_i,
    output logic                         ar_ready_o,
    input  logic [`AXI_ADDR_WIDTH-1:0]   ar_addr_i,
    input  logic [`AXI_ID_WIDTH-1:0]     ar_id_i,
    input  logic [`AXI_LEN_WIDTH-1:0]    ar_len_i,
    input  logic [`AXI_SIZE_WIDTH-1:0]   ar_size_i,
    input  logic [`AXI_BURST_WIDTH-1:0]  ar_burst_i,

    output logic                         r_valid_o,
    input  logic                         r_ready_i,
    output logic [`AXI_DATA_WIDTH-1:0]   r_data_o,
    output logic [`AXI_RESP_WIDTH-1:0]   r_resp_o,
    output logic                         r_last_o,
    output logic [`AXI_ID_WIDTH-1:0]     r_id_o,

    output logic                         mtip_o,
    output logic                         msip_o
);

    logic [`AXI_ADDR_WIDTH-1:0] rd_addr;
    logic [`AXI_DATA_WIDTH-1:0] rd_data;
    logic                       rd_hit;
    logic                       wr_en;
    logic [`AXI_ADDR_WIDTH-1:0] wr_addr;
    logic [`AXI_DATA_WIDTH-1:0] wr_data;
    logic [`AXI_STRB_WIDTH-1:0] wr_strb;
    logic                       wr_hit;

    clint_axi_rd u_axi_rd (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .ar_addr_i  (ar_addr_i),
        .ar_id_i    (ar_id_i),
        .ar_len_i   (ar_len_i),
        .ar_size_i  (ar_size_i),
        .ar_burst_i (ar_burst_i),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .r_data_o   (r_data_o),
        .r_resp_o   (r_resp_o),
        .r_last_o   (r_last_o),
        .r_id_o     (r_id_o),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data),
        .rd_hit_i   (rd_hit)
    );

    clint_axi_wr u_axi_wr (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .aw_addr_i  (aw_addr_i),
        .aw_id_i    (aw_id_i),
        .aw_len_i   (aw_len_i),
        .aw_size_i  (aw_size_i),
        .aw_burst_i (aw_burst_i),
        .w_valid_i  (w_valid_i),
        .w_ready_o  (w_ready_o),
        .w_data_i   (w_data_i),
        .w_strb_i   (w_strb_i),
        .w_last_i   (w_last_i),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .b_resp_o   (b_resp_o),
        .b_id_o     (b_id_o),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .wr_strb_o  (wr_strb),
        .wr_hit_i   (wr_hit)
    );

    clint_regs u_regs (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .rd_hit_o  (rd_hit),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .wr_strb_i (wr_strb),
        .wr_hit_o  (wr_hit),
        .mtip_o    (mtip_o),
        .msip_o    (msip_o)
    );

endmodule

/* common/clint_params.svh */
`ifndef CLINT_PARAMS_SVH
`define CLINT_PARAMS_SVH

// AXI4 field widths for the slave port.
`define AXI_ADDR_WIDTH  32
`define AXI_DATA_WIDTH  32
`define AXI_STRB_WIDTH  4
`define AXI_ID_WIDTH    4
`define AXI_LEN_WIDTH   8
`define AXI_SIZE_WIDTH  3
`define AXI_BURST_WIDTH 2
`define AXI_RESP_WIDTH  2

// register map of the interruptor for a single hart.
`define CLINT_MSIP_ADDR        32'h0200_0000
`define CLINT_MTIMECMP_LO_ADDR 32'h0200_4000
`define CLINT_MTIMECMP_HI_ADDR 32'h0200_4004
`define CLINT_MTIME_LO_ADDR    32'h0200_BFF8
`define CLINT_MTIME_HI_ADDR    32'h0200_BFFC

// aclk cycles per mtime increment.
`define CLINT_TICK_DIV 4

`endif

/* common/clint_pkg.sv */
`include "clint_params.svh"

package clint_pkg;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } clint_half_t;

    // the full view counts and compares, the half view is what the bus sees.
    typedef union packed {
        logic [63:0] full;
        clint_half_t half;
    } clint_word_u;

    typedef enum logic [`AXI_RESP_WIDTH-1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } clint_resp_e;

endpackage

/* files.f */
+incdir+common
common/clint_pkg.sv
clint/clint_axi_rd.sv
clint/clint_axi_wr.sv
clint/clint_regs.sv
clint/clint_top.sv
tb/clint_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module clint_tb -o clint_sim \
    && ./obj_dir/clint_sim > sim.log \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "sim passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0

/* tb/clint_tb.sv */
`timescale 1ns/1ps
`include "clint_params.svh"

module clint_tb;
    import clint_pkg::*;

    localparam int   HS_LIMIT = 16;
    localparam logic WR       = 1'b1;
    localparam logic RD       = 1'b0;

    typedef enum logic [2:0] {
        CHK_EXACT,
        CHK_MTIME,
        CHK_MSIP,
        CHK_MTIP_LOW,
        CHK_MTIP_HIGH
    } chk_mode_e;

    typedef struct packed {
        logic                       is_write;
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_DATA_WIDTH-1:0] data;
        logic [`AXI_STRB_WIDTH-1:0] strb;
        clint_resp_e                resp;
        logic [`AXI_DATA_WIDTH-1:0] exp_data;
        chk_mode_e                  mode;
    } entry_t;

    logic                        aclk;
    logic                        areset_n;
    logic                        aw_valid_i;
    logic                        aw_ready_o;
    logic [`AXI_ADDR_WIDTH-1:0]  aw_addr_i;
    logic [`AXI_ID_WIDTH-1:0]    aw_id_i;
    logic [`AXI_LEN_WIDTH-1:0]   aw_len_i;
    logic [`AXI_SIZE_WIDTH-1:0]  aw_size_i;
    logic [`AXI_BURST_WIDTH-1:0] aw_burst_i;
    logic                        w_valid_i;
    logic                        w_ready_o;
    logic [`AXI_DATA_WIDTH-1:0]  w_data_i;
    logic [`AXI_STRB_WIDTH-1:0]  w_strb_i;
    logic                        w_last_i;
    logic                        b_valid_o;
    logic                        b_ready_i;
    logic [`AXI_RESP_WIDTH-1:0]  b_resp_o;
    logic [`AXI_ID_WIDTH-1:0]    b_id_o;
    logic                        ar_valid_i;
    logic                        ar_ready_o;
    logic [`AXI_ADDR_WIDTH-1:0]  ar_addr_i;
    logic [`AXI_ID_WIDTH-1:0]    ar_id_i;
    logic [`AXI_LEN_WIDTH-1:0]   ar_len_i;
    logic [`AXI_SIZE_WIDTH-1:0]  ar_size_i;
    logic [`AXI_BURST_WIDTH-1:0] ar_burst_i;
    logic                        r_valid_o;
    logic                        r_ready_i;
    logic [`AXI_DATA_WIDTH-1:0]  r_data_o;
    logic [`AXI_RESP_WIDTH-1:0]  r_resp_o;
    logic                        r_last_o;
    logic [`AXI_ID_WIDTH-1:0]    r_id_o;
    logic                        mtip_o;
    logic                        msip_o;

    entry_t      stim_q[$];
    int          err_cnt;
    int          cycle_cnt;
    int          timeout_limit;
    int          last_w_edge;
    int          last_ar_edge;
    int          mtime_wr_edge;
    int          mtip_high_since;
    clint_word_u mtime_model;

    clint_top dut (
        .aclk(aclk), .areset_n(areset_n),
        .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o), .aw_addr_i(aw_addr_i),
        .aw_id_i(aw_id_i), .aw_len_i(aw_len_i), .aw_size_i(aw_size_i),
        .aw_burst_i(aw_burst_i),
        .w_valid_i(w_valid_i), .w_ready_o(w_ready_o), .w_data_i(w_data_i),
        .w_strb_i(w_strb_i), .w_last_i(w_last_i),
        .b_valid_o(b_valid_o), .b_ready_i(b_ready_i), .b_resp_o(b_resp_o), .b_id_o(b_id_o),
        .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o), .ar_addr_i(ar_addr_i),
        .ar_id_i(ar_id_i), .ar_len_i(ar_len_i), .ar_size_i(ar_size_i),
        .ar_burst_i(ar_burst_i),
        .r_valid_o(r_valid_o), .r_ready_i(r_ready_i), .r_data_o(r_data_o),
        .r_resp_o(r_resp_o), .r_last_o(r_last_o), .r_id_o(r_id_o),
        .mtip_o(mtip_o), .msip_o(msip_o)
    );

    always #10 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles, a transaction never finished", cycle_cnt);
            $display("errors: %0d, table entries: %0d", err_cnt + 1, stim_q.size());
            $display("sim failed");
            $finish;
        end
    end

    // the edge on which mtip_o was first seen high since it was last low.
    always @(negedge aclk) begin
        if (mtip_o !== 1'b1) begin
            mtip_high_since <= 0;
        end else if (mtip_high_since == 0) begin
            mtip_high_since <= cycle_cnt;
        end
    end

    task automatic step_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] got_v);
        err_cnt++;
        $display("Fail at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic add_entry(input logic is_write, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             input clint_resp_e resp, input logic [31:0] exp_data,
                             input chk_mode_e mode);
        entry_t e;
        e = '{is_write, addr, data, strb, resp, exp_data, mode};
        stim_q.push_back(e);
    endtask

    task automatic axi_write(input entry_t e, input logic [`AXI_ID_WIDTH-1:0] id,
                             output logic ok);
        int                         n;
        int                         stall;
        logic [`AXI_RESP_WIDTH-1:0] resp_seen;
        logic [`AXI_ID_WIDTH-1:0]   id_seen;
        ok = 1'b0;
        aw_valid_i = 1'b1;
        aw_addr_i  = e.addr;
        aw_id_i    = id;
        n = 0;
        while (!aw_ready_o && n < HS_LIMIT) begin
            step_cycle();
            n++;
        end
        if (!aw_ready_o) begin
            report_problem("the write address was never accepted");
            aw_valid_i = 1'b0;
            return;
        end
        step_cycle();
        aw_valid_i = 1'b0;
        w_valid_i  = 1'b1;
        w_data_i   = e.data;
        w_strb_i   = e.strb;
        n = 0;
        while (!w_ready_o && n < HS_LIMIT) begin
            step_cycle();
            n++;
        end
        if (!w_ready_o) begin
            report_problem("the write data beat was never accepted");
            w_valid_i = 1'b0;
            return;
        end
        step_cycle();
        last_w_edge = cycle_cnt;
        w_valid_i = 1'b0;
        n = 0;
        while (!b_valid_o && n < HS_LIMIT) begin
            step_cycle();
            n++;
        end
        if (!b_valid_o) begin
            report_problem("no write response came back");
            return;
        end
        resp_seen = b_resp_o;
        id_seen   = b_id_o;
        // hold b_ready low for a while, the response must not move.
        stall = int'($urandom % 4);
        repeat (stall) begin
            step_cycle();
            if (b_valid_o !== 1'b1) report_mismatch("b_valid_o", 1, b_valid_o);
            if (b_resp_o !== resp_seen) report_mismatch("b_resp_o", resp_seen, b_resp_o);
        end
        b_ready_i = 1'b1;
        step_cycle();
        b_ready_i = 1'b0;
        if (resp_seen !== e.resp) report_mismatch("b_resp_o", e.resp, resp_seen);
        if (id_seen !== id) report_mismatch("b_id_o", id, id_seen);
        ok = 1'b1;
    endtask

    task automatic axi_read(input entry_t e, input logic [`AXI_ID_WIDTH-1:0] id,
                            output logic [`AXI_DATA_WIDTH-1:0] data, output logic ok);
        int                         n;
        int                         stall;
        logic [`AXI_RESP_WIDTH-1:0] resp_seen;
        logic [`AXI_ID_WIDTH-1:0]   id_seen;
        logic                       last_seen;
        ok   = 1'b0;
        data = '0;
        ar_valid_i = 1'b1;
        ar_addr_i  = e.addr;
        ar_id_i    = id;
        n = 0;
        while (!ar_ready_o && n < HS_LIMIT) begin
            step_cycle();
            n++;
        end
        if (!ar_ready_o) begin
            report_problem("the read address was never accepted");
            ar_valid_i = 1'b0;
            return;
        end
        step_cycle();
        last_ar_edge = cycle_cnt;
        ar_valid_i = 1'b0;
        n = 0;
        while (!r_valid_o && n < HS_LIMIT) begin
            step_cycle();
            n++;
        end
        if (!r_valid_o) begin
            report_problem("no read data came back");
            return;
        end
        data      = r_data_o;
        resp_seen = r_resp_o;
        id_seen   = r_id_o;
        last_seen = r_last_o;
        stall = int'($urandom % 4);
        repeat (stall) begin
            step_cycle();
            if (r_valid_o !== 1'b1) report_mismatch("r_valid_o", 1, r_valid_o);
            if (r_data_o !== data) report_mismatch("r_data_o", data, r_data_o);
        end
        r_ready_i = 1'b1;
        step_cycle();
        r_ready_i = 1'b0;
        if (resp_seen !== e.resp) report_mismatch("r_resp_o", e.resp, resp_seen);
        if (id_seen !== id) report_mismatch("r_id_o", id, id_seen);
        if (last_seen !== 1'b1) report_mismatch("r_last_o", 1, last_seen);
        ok = 1'b1;
    endtask

    task automatic check_read_data(input entry_t e, input logic [`AXI_DATA_WIDTH-1:0] data);
        logic [63:0] upper;
        if (e.mode == CHK_MTIME) begin
            // at most one tick per divider period since the write, plus a partial one.
            upper = mtime_model.full + 64'((last_ar_edge - mtime_wr_edge) / `CLINT_TICK_DIV)
                    + 64'd1;
            if (data < mtime_model.half.lo)
                report_mismatch("r_data_o (mtime low bound)", mtime_model.half.lo, data);
            if (data > upper[31:0])
                report_mismatch("r_data_o (mtime high bound)", upper[31:0], data);
        end else if (data !== e.exp_data) begin
            report_mismatch("r_data_o", e.exp_data, data);
        end
    endtask

    task automatic check_after_write(input entry_t e);
        case (e.mode)
            CHK_MSIP: begin
                if (msip_o !== e.exp_data[0]) report_mismatch("msip_o", e.exp_data[0], msip_o);
            end
            CHK_MTIP_LOW: begin
                repeat (3) begin
                    if (mtip_o !== 1'b0) report_mismatch("mtip_o", 0, mtip_o);
                    step_cycle();
                end
            end
            CHK_MTIP_HIGH: begin
                if (mtip_o !== 1'b1)
                    report_mismatch("mtip_o", 1, mtip_o);
                else if (mtip_high_since <= last_w_edge)
                    report_problem("mtip_o was already high before the mtimecmp write");
                else if (mtip_high_since - last_w_edge > 2)
                    report_problem("mtip_o rose more than 2 cycles after the mtimecmp write");
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        entry_t                     e;
        logic [`AXI_ID_WIDTH-1:0]   id;
        logic [`AXI_DATA_WIDTH-1:0] data;
        logic                       ok;
        int unsigned                seed_ret;
        seed_ret = $urandom(32'h32c3_598d);
        aclk = 1'b0;
        areset_n = 1'b1;
        aw_valid_i = 1'b0;
        aw_addr_i = '0;
        aw_id_i = '0;
        aw_len_i = '0;
        aw_size_i = 3'd2;
        aw_burst_i = 2'd1;
        w_valid_i = 1'b0;
        w_data_i = '0;
        w_strb_i = '0;
        w_last_i = 1'b1;
        b_ready_i = 1'b0;
        ar_valid_i = 1'b0;
        ar_addr_i = '0;
        ar_id_i = '0;
        ar_len_i = '0;
        ar_size_i = 3'd2;
        ar_burst_i = 2'd1;
        r_ready_i = 1'b0;
        err_cnt = 0;
        cycle_cnt = 0;
        mtip_high_since = 0;
        mtime_model.full = '0;
        mtime_wr_edge = 0;

        add_entry(WR, `CLINT_MSIP_ADDR, 32'h0000_0001, 4'hf, OKAY, 32'h1, CHK_MSIP);
        add_entry(RD, `CLINT_MSIP_ADDR, 32'h0, 4'h0, OKAY, 32'h1, CHK_EXACT);
        add_entry(WR, `CLINT_MSIP_ADDR, 32'hffff_fffe, 4'hf, OKAY, 32'h0, CHK_MSIP);
        add_entry(RD, `CLINT_MSIP_ADDR, 32'h0, 4'h0, OKAY, 32'h0, CHK_EXACT);
        add_entry(WR, `CLINT_MTIMECMP_HI_ADDR, 32'h1234_5678, 4'hf, OKAY, 32'h0, CHK_MTIP_LOW);
        add_entry(RD, `CLINT_MTIMECMP_HI_ADDR, 32'h0, 4'h0, OKAY, 32'h1234_5678, CHK_EXACT);
        // bytes 1 and 3 keep their old value.
        add_entry(WR, `CLINT_MTIMECMP_HI_ADDR, 32'haabb_ccdd, 4'h5, OKAY, 32'h0, CHK_MTIP_LOW);
        add_entry(RD, `CLINT_MTIMECMP_HI_ADDR, 32'h0, 4'h0, OKAY, 32'h12bb_56dd, CHK_EXACT);
        add_entry(WR, `CLINT_MTIMECMP_LO_ADDR, 32'h0000_0000, 4'hf, OKAY, 32'h0, CHK_MTIP_LOW);
        add_entry(WR, `CLINT_MTIMECMP_LO_ADDR, 32'hcafe_f00d, 4'hc, OKAY, 32'h0, CHK_EXACT);
        add_entry(RD, `CLINT_MTIMECMP_LO_ADDR, 32'h0, 4'h0, OKAY, 32'hcafe_0000, CHK_EXACT);
        add_entry(WR, `CLINT_MTIME_HI_ADDR, 32'h0000_0000, 4'hf, OKAY, 32'h0, CHK_EXACT);
        add_entry(WR, `CLINT_MTIME_LO_ADDR, 32'h0000_1000, 4'hf, OKAY, 32'h0, CHK_EXACT);
        add_entry(RD, `CLINT_MTIME_LO_ADDR, 32'h0, 4'h0, OKAY, 32'h0, CHK_MTIME);
        add_entry(RD, `CLINT_MTIME_HI_ADDR, 32'h0, 4'h0, OKAY, 32'h0, CHK_EXACT);
        add_entry(WR, 32'h0200_0004, 32'h1234_5678, 4'hf, SLVERR, 32'h0, CHK_EXACT);
        add_entry(RD, 32'h0200_8000, 32'h0, 4'h0, SLVERR, 32'h0, CHK_EXACT);
        add_entry(WR, `CLINT_MTIMECMP_HI_ADDR, 32'h0000_0000, 4'hf, OKAY, 32'h0, CHK_MTIP_LOW);
        add_entry(WR, `CLINT_MTIMECMP_LO_ADDR, 32'h0000_0800, 4'hf, OKAY, 32'h0, CHK_MTIP_HIGH);
        add_entry(RD, `CLINT_MTIMECMP_LO_ADDR, 32'h0, 4'h0, OKAY, 32'h0000_0800, CHK_EXACT);
        add_entry(RD, `CLINT_MTIME_LO_ADDR, 32'h0, 4'h0, OKAY, 32'h0, CHK_MTIME);
        add_entry(WR, `CLINT_MSIP_ADDR, 32'h0000_0001, 4'h0, OKAY, 32'h0, CHK_MSIP);
        add_entry(RD, 32'h0200_bff4, 32'h0, 4'h0, SLVERR, 32'h0, CHK_EXACT);
        timeout_limit = 40 * stim_q.size() + 200;

        repeat (10) step_cycle();
        areset_n = 1'b0;
        step_cycle();
        if (ar_ready_o !== 1'b1) report_mismatch("ar_ready_o", 1, ar_ready_o);
        if (aw_ready_o !== 1'b1) report_mismatch("aw_ready_o", 1, aw_ready_o);
        if (r_valid_o !== 1'b0) report_mismatch("r_valid_o", 0, r_valid_o);
        if (w_ready_o !== 1'b0) report_mismatch("w_ready_o", 0, w_ready_o);
        if (b_valid_o !== 1'b0) report_mismatch("b_valid_o", 0, b_valid_o);
        if (mtip_o !== 1'b0) report_mismatch("mtip_o", 0, mtip_o);
        if (msip_o !== 1'b0) report_mismatch("msip_o", 0, msip_o);

        foreach (stim_q[i]) begin
            e  = stim_q[i];
            id = `AXI_ID_WIDTH'($urandom % 16);
            if (e.is_write) begin
                axi_write(e, id, ok);
                if (ok && e.addr == `CLINT_MTIME_LO_ADDR) begin
                    mtime_model.half.lo = e.data;
                    mtime_wr_edge = last_w_edge;
                end
                if (ok && e.addr == `CLINT_MTIME_HI_ADDR) begin
                    mtime_model.half.hi = e.data;
                end
                if (ok) check_after_write(e);
            end else begin
                axi_read(e, id, data, ok);
                if (ok) check_read_data(e, data);
            end
            step_cycle();
        end

        $display("errors: %0d, table entries: %0d", err_cnt, stim_q.size());
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
